// File: filelist.f
+incdir+logic
logic/sdram_sched_pkg.sv
logic/sdram_bank_if.sv
logic/sdram_bank_tracker.sv
logic/sdram_refresh_timer.sv
logic/sdram_cmd_fsm.sv
logic/sdram_sched_top.sv
test/tb_sdram_sched.sv

// File: logic/sdram_bank_if.sv
// Scheduler to bank tracker interface with its two modports
`default_nettype none

interface sdram_bank_if;
  import sdram_sched_pkg::*;

  localparam int NBANKS = $bits(bank_mask_t);

  // Command strobes are high in the cycle the command is registered
  logic       cmd_act;
  logic       cmd_pre;
  logic       cmd_pre_all;
  logic       cmd_ref;
  bank_t      cmd_ba;
  row_t       cmd_row;

  // Bank state as seen by the scheduler
  bank_mask_t bank_open;
  row_t       open_row [NBANKS];
  bank_mask_t act_ready;
  bank_mask_t rw_ready;
  bank_mask_t pre_ready;
  logic       all_closed_ready;

  modport scheduler (
    output cmd_act, cmd_pre, cmd_pre_all, cmd_ref, cmd_ba, cmd_row,
    input  bank_open, open_row, act_ready, rw_ready, pre_ready, all_closed_ready
  );

  modport tracker (
    input  cmd_act, cmd_pre, cmd_pre_all, cmd_ref, cmd_ba, cmd_row,
    output bank_open, open_row, act_ready, rw_ready, pre_ready, all_closed_ready
  );

endinterface

`default_nettype wire

// File: logic/sdram_bank_tracker.sv
// Bank tracker with open rows, per-bank tRCD/tRP/tRAS timers and global tRC timer
`default_nettype none

`include "sdram_sched_settings.svh"

module sdram_bank_tracker (
  input  logic          clk_i,
  input  logic          rst_ni,
  sdram_bank_if.tracker bank
);
  import sdram_sched_pkg::*;

  localparam int NBANKS = $bits(bank_mask_t);
  localparam int TW     = `TIMER_BITS;

  // Counters reach zero one cycle before the next command may be decided
  localparam logic [TW-1:0] TRCD_LOAD = TW'(`T_RCD_CYC - 1);
  localparam logic [TW-1:0] TRP_LOAD  = TW'(`T_RP_CYC - 1);
  localparam logic [TW-1:0] TRAS_LOAD = TW'(`T_RAS_CYC - 1);
  localparam logic [TW-1:0] TRC_LOAD  = TW'(`T_RC_CYC - 1);

  logic [TW-1:0] trcd_cnt [NBANKS];
  logic [TW-1:0] trp_cnt  [NBANKS];
  logic [TW-1:0] tras_cnt [NBANKS];
  logic [TW-1:0] trc_cnt;
  bank_mask_t    act_ld;
  bank_mask_t    pre_ld;
  bank_mask_t    trp_done;

  // Load or count down to zero and hold
  function automatic logic [TW-1:0] tick(input logic          load,
                                         input logic [TW-1:0] load_val,
                                         input logic [TW-1:0] cnt);
    logic [TW-1:0] nxt;
    nxt = cnt;
    if (load)
      nxt = load_val;
    else if (cnt != '0)
      nxt = cnt - 1'b1;
    return nxt;
  endfunction

  ////////////////////
  // Strobe decode
  ////////////////////
  always_comb
  begin
    act_ld = '0;
    pre_ld = '0;
    if (bank.cmd_act)
      act_ld[bank.cmd_ba] = 1'b1;
    if (bank.cmd_pre)
      pre_ld[bank.cmd_ba] = 1'b1;
    // PRE-all closes every bank
    if (bank.cmd_pre_all)
      pre_ld = '1;
  end

  ////////////////////
  // Bank status and timers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bank.bank_open <= '0;
      trc_cnt        <= '0;
      for (int b = 0; b < NBANKS; b++)
      begin
        trcd_cnt[b] <= '0;
        trp_cnt[b]  <= '0;
        tras_cnt[b] <= '0;
      end
    end
    else
    begin
      bank.bank_open <= (bank.bank_open | act_ld) & ~pre_ld;
      // ACT-to-ACT and REF-to-ACT/REF share one counter
      trc_cnt        <= tick(bank.cmd_act | bank.cmd_ref, TRC_LOAD, trc_cnt);
      for (int b = 0; b < NBANKS; b++)
      begin
        trcd_cnt[b] <= tick(act_ld[b], TRCD_LOAD, trcd_cnt[b]);
        tras_cnt[b] <= tick(act_ld[b], TRAS_LOAD, tras_cnt[b]);
        trp_cnt[b]  <= tick(pre_ld[b], TRP_LOAD, trp_cnt[b]);
      end
    end
  end

  // Open row per bank is valid only while the bank is open
  always_ff @(posedge clk_i)
  begin
    if (bank.cmd_act)
      bank.open_row[bank.cmd_ba] <= bank.cmd_row;
  end

  ////////////////////
  // Ready masks
  ////////////////////
  always_comb
  begin
    for (int b = 0; b < NBANKS; b++)
    begin
      trp_done[b]       = (trp_cnt[b] == '0);
      bank.act_ready[b] = trp_done[b] && (trc_cnt == '0);
      bank.rw_ready[b]  = (trcd_cnt[b] == '0);
      bank.pre_ready[b] = (tras_cnt[b] == '0);
    end
  end

  assign bank.all_closed_ready = ~|bank.bank_open && (&trp_done) && (trc_cnt == '0);

endmodule

`default_nettype wire

// File: logic/sdram_cmd_fsm.sv
// Command FSM that picks ACT/PRE/RD/WR/REF and registers the SDRAM command bus
`default_nettype none

module sdram_cmd_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  sdram_sched_pkg::bank_t      req_ba_i,
  input  sdram_sched_pkg::row_t       req_row_i,
  input  sdram_sched_pkg::col_t       req_col_i,
  output logic                        ack_o,
  output sdram_sched_pkg::sdram_cmd_e cmd_o,
  output sdram_sched_pkg::bank_t      ba_o,
  output sdram_sched_pkg::sdram_addr_t addr_o,
  input  logic                        ref_pending_i,
  input  logic                        ref_urgent_i,
  output logic                        ref_done_o,
  sdram_bank_if.scheduler             bank
);
  import sdram_sched_pkg::*;

  sched_state_e state_q, state_d;
  sdram_cmd_e   cmd_q, cmd_d;
  bank_t        ba_q, ba_d;
  sdram_addr_t  addr_q, addr_d;
  logic         ack_q;
  logic         req_vld;
  logic         row_hit;
  logic         ref_go;
  logic         open_pre_ok;
  logic         do_act, do_pre, do_pre_all, do_ref, do_rw;

  // Request already served while ack_o is high
  assign req_vld     = req_i & ~ack_q;
  assign row_hit     = bank.bank_open[req_ba_i] && (bank.open_row[req_ba_i] == req_row_i);
  // Refresh goes when urgent or when no request waits
  assign ref_go      = ref_urgent_i | (ref_pending_i & ~req_vld);
  assign open_pre_ok = &(bank.pre_ready | ~bank.bank_open);

  ////////////////////
  // Decision
  ////////////////////
  always_comb
  begin
    state_d    = state_q;
    do_act     = 1'b0;
    do_pre     = 1'b0;
    do_pre_all = 1'b0;
    do_ref     = 1'b0;
    do_rw      = 1'b0;
    case (state_q)
      SCHED_RUN:
      begin
        if (ref_go)
        begin
          if (bank.all_closed_ready)
            do_ref = 1'b1;
          else if (|bank.bank_open && open_pre_ok)
          begin
            do_pre_all = 1'b1;
            state_d    = SCHED_REF_WAIT;
          end
        end
        else if (req_vld)
        begin
          // Open the bank on the right row and then access it
          if (!bank.bank_open[req_ba_i])
            do_act = bank.act_ready[req_ba_i];
          else if (!row_hit)
            do_pre = bank.pre_ready[req_ba_i];
          else
            do_rw = bank.rw_ready[req_ba_i];
        end
      end
      SCHED_REF_WAIT:
      begin
        if (bank.all_closed_ready)
        begin
          do_ref  = 1'b1;
          state_d = SCHED_RUN;
        end
      end
      default: state_d = SCHED_RUN;
    endcase
  end

  // Command bus encoding
  always_comb
  begin
    cmd_d  = CMD_NOP;
    ba_d   = req_ba_i;
    addr_d = '0;
    if (do_ref)
    begin
      cmd_d = CMD_REF;
      ba_d  = '0;
    end
    else if (do_pre_all)
    begin
      cmd_d      = CMD_PRE;
      ba_d       = '0;
      addr_d[10] = 1'b1;
    end
    else if (do_pre)
      cmd_d = CMD_PRE;
    else if (do_act)
    begin
      cmd_d  = CMD_ACT;
      addr_d = sdram_addr_t'(req_row_i);
    end
    else if (do_rw)
    begin
      cmd_d                        = we_i ? CMD_WR : CMD_RD;
      // Bit 10 stays low for no auto-precharge
      addr_d[$bits(col_t)-1:0] = req_col_i;
    end
  end

  // Strobes to the tracker and refresh timer
  assign bank.cmd_act     = do_act;
  assign bank.cmd_pre     = do_pre;
  assign bank.cmd_pre_all = do_pre_all;
  assign bank.cmd_ref     = do_ref;
  assign bank.cmd_ba      = req_ba_i;
  assign bank.cmd_row     = req_row_i;
  assign ref_done_o       = do_ref;

  ////////////////////
  // Output registers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= SCHED_RUN;
      cmd_q   <= CMD_NOP;
      ack_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      cmd_q   <= cmd_d;
      ack_q   <= do_rw;
    end
  end

  // Bank and address only change with a real command
  always_ff @(posedge clk_i)
  begin
    if (cmd_d != CMD_NOP)
    begin
      ba_q   <= ba_d;
      addr_q <= addr_d;
    end
  end

  assign cmd_o  = cmd_q;
  assign ba_o   = ba_q;
  assign addr_o = addr_q;
  assign ack_o  = ack_q;

endmodule

`default_nettype wire

// File: logic/sdram_refresh_timer.sv
// Refresh interval counter and pending-refresh bookkeeping
`default_nettype none

`include "sdram_sched_settings.svh"

module sdram_refresh_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_done_i,
  output logic ref_pending_o,
  output logic ref_urgent_o
);

  localparam int RW = `REF_CNT_BITS;
  // One spare bit above the urgent level
  localparam int PW = $clog2(`REF_URGENT + 1) + 1;

  localparam logic [RW-1:0] REFI_LOAD  = RW'(`T_REFI_CYC - 1);
  localparam logic [PW-1:0] URGENT_LVL = PW'(`REF_URGENT);

  logic [RW-1:0] refi_cnt;
  logic          refi_expired;
  logic [PW-1:0] pend_cnt;

  assign refi_expired = (refi_cnt == '0);

  // Free-running interval with one expiry every T_REFI_CYC cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      refi_cnt <= REFI_LOAD;
    else if (refi_expired)
      refi_cnt <= REFI_LOAD;
    else
      refi_cnt <= refi_cnt - 1'b1;
  end

  // Expiry and REF in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_cnt <= '0;
    else
    begin
      case ({refi_expired, ref_done_i})
        2'b10:   pend_cnt <= pend_cnt + 1'b1;
        2'b01:   pend_cnt <= (pend_cnt != '0) ? pend_cnt - 1'b1 : pend_cnt;
        default: pend_cnt <= pend_cnt;
      endcase
    end
  end

  assign ref_pending_o = (pend_cnt != '0);
  assign ref_urgent_o  = (pend_cnt >= URGENT_LVL);

endmodule

`default_nettype wire

// File: logic/sdram_sched_pkg.sv
// Shared vector types and command/state enums of the SDRAM scheduler
`default_nettype none

`include "sdram_sched_settings.svh"

package sdram_sched_pkg;

  // Request and bus fields
  typedef logic [`SDRAM_BA_BITS-1:0]        bank_t;
  typedef logic [`SDRAM_ROW_BITS-1:0]       row_t;
  typedef logic [`SDRAM_COL_BITS-1:0]       col_t;
  typedef logic [`SDRAM_ADDR_BITS-1:0]      sdram_addr_t;

  // One bit per bank
  typedef logic [(1 << `SDRAM_BA_BITS)-1:0] bank_mask_t;

  // Encoded as {RAS_n, CAS_n, WE_n}
  typedef enum logic [2:0] {
    CMD_NOP = 3'b111,
    CMD_ACT = 3'b011,
    CMD_RD  = 3'b101,
    CMD_WR  = 3'b100,
    CMD_PRE = 3'b010,
    CMD_REF = 3'b001
  } sdram_cmd_e;

  typedef enum logic {
    SCHED_RUN      = 1'b0,
    SCHED_REF_WAIT = 1'b1
  } sched_state_e;

endpackage

`default_nettype wire

// File: logic/sdram_sched_settings.svh
// Width, timing limit and refresh interval macros for the SDRAM scheduler
`ifndef SDRAM_SCHED_SETTINGS_SVH
`define SDRAM_SCHED_SETTINGS_SVH

// SDRAM geometry
`define SDRAM_BA_BITS   2
`define SDRAM_ROW_BITS  13
`define SDRAM_COL_BITS  9
`define SDRAM_ADDR_BITS 13

// Bank timing limits, in clock cycles on the command bus
`define T_RCD_CYC 2
`define T_RP_CYC  2
`define T_RAS_CYC 5
`define T_RC_CYC  7

// Auto-refresh interval and forced-refresh threshold
`define T_REFI_CYC 200
`define REF_URGENT 4

// Counter widths
`define TIMER_BITS   4
`define REF_CNT_BITS 16

`endif

// File: logic/sdram_sched_top.sv
// SDRAM command scheduler top: bank tracker, refresh timer and command FSM
`default_nettype none

module sdram_sched_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Requester side
  input  logic                         req_i,
  input  logic                         we_i,
  input  sdram_sched_pkg::bank_t       req_ba_i,
  input  sdram_sched_pkg::row_t        req_row_i,
  input  sdram_sched_pkg::col_t        req_col_i,
  output logic                         ack_o,

  // SDRAM command bus, registered
  output sdram_sched_pkg::sdram_cmd_e  cmd_o,
  output sdram_sched_pkg::bank_t       ba_o,
  output sdram_sched_pkg::sdram_addr_t addr_o
);

  logic ref_pending;
  logic ref_urgent;
  logic ref_done;

  sdram_bank_if bank_if ();

  ////////////////////
  // Bank state
  ////////////////////
  sdram_bank_tracker u_bank_tracker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank   (bank_if.tracker)
  );

  // Refresh scheduling
  sdram_refresh_timer u_refresh_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ref_done_i    (ref_done),
    .ref_pending_o (ref_pending),
    .ref_urgent_o  (ref_urgent)
  );

  ////////////////////
  // Command selection
  ////////////////////
  sdram_cmd_fsm u_cmd_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .req_ba_i      (req_ba_i),
    .req_row_i     (req_row_i),
    .req_col_i     (req_col_i),
    .ack_o         (ack_o),
    .cmd_o         (cmd_o),
    .ba_o          (ba_o),
    .addr_o        (addr_o),
    .ref_pending_i (ref_pending),
    .ref_urgent_i  (ref_urgent),
    .ref_done_o    (ref_done),
    .bank          (bank_if.scheduler)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the SDRAM scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sdram_sched -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: test/tb_sdram_sched.sv
// Testbench for the SDRAM scheduler with stimulus, bank model, expected commands and checks
`default_nettype none

`include "sdram_sched_settings.svh"

module tb_sdram_sched;
  timeunit 1ns;
  timeprecision 100ps;
  import sdram_sched_pkg::*;

  localparam int NBANKS      = 1 << `SDRAM_BA_BITS;
  localparam int N_RAND      = 300;
  localparam int ACK_TIMEOUT = 200;
  localparam int REF_SPAN    = `T_REFI_CYC * `REF_URGENT + 50;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        we_i;
  bank_t       req_ba_i;
  row_t        req_row_i;
  col_t        req_col_i;
  logic        ack_o;
  sdram_cmd_e  cmd_o;
  bank_t       ba_o;
  sdram_addr_t addr_o;

  // Bank model rebuilt from the observed command bus
  bank_mask_t  model_open;
  row_t        model_row [NBANKS];
  int          act_t [NBANKS];
  int          pre_t [NBANKS];
  int          last_act, last_ref, ref_mark, cyc;
  int          ack_cnt, act_cnt, pre_cnt, ref_cnt, req_cnt;
  // Request as seen in the decision cycle
  logic        prev_req, prev_we;
  bank_t       prev_ba;
  row_t        prev_row;
  col_t        prev_col;
  sdram_cmd_e  exp_cmd;
  sdram_addr_t exp_addr;
  int          b;
  integer      seed;
  int          a0, p0;

  sdram_sched_top uut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .we_i      (we_i),
    .req_ba_i  (req_ba_i),
    .req_row_i (req_row_i),
    .req_col_i (req_col_i),
    .ack_o     (ack_o),
    .cmd_o     (cmd_o),
    .ba_o      (ba_o),
    .addr_o    (addr_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val)
      stop_with_failure($sformatf("error: %s expected %0h actual %0h", name, exp_val, act_val));
  endtask

  // Next command and address the model expects for a request
  function automatic sdram_cmd_e expect_cmd(input bank_t ba, input row_t row, input col_t col,
                                            input logic we, output sdram_addr_t addr);
    addr = '0;
    if (!model_open[ba])
    begin
      addr = sdram_addr_t'(row);
      return CMD_ACT;
    end
    if (model_row[ba] != row)
      return CMD_PRE;
    // Column only with bit 10 low
    addr[`SDRAM_COL_BITS-1:0] = col;
    return we ? CMD_WR : CMD_RD;
  endfunction

  // One clock and then the drive offset
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  // Hold the request until ack_o within a bounded wait
  task automatic issue_request(input bank_t ba, input row_t row, input col_t col,
                               input logic we);
    int waited;
    waited    = 0;
    req_i     = 1'b1;
    we_i      = we;
    req_ba_i  = ba;
    req_row_i = row;
    req_col_i = col;
    do
    begin
      step();
      waited++;
    end while (!ack_o && waited < ACK_TIMEOUT);
    if (!ack_o)
      stop_with_failure($sformatf("timeout: no ack_o within %0d cycles for bank %0d row %0h",
                                  ACK_TIMEOUT, ba, row));
    req_cnt++;
  endtask

  ////////////////////
  // Compare and update the model
  ////////////////////
  always @(negedge clk_i)
  begin
    if (!rst_ni)
    begin
      model_open = '0;
      for (int i = 0; i < NBANKS; i++)
      begin
        act_t[i] = -100;
        pre_t[i] = -100;
      end
      last_act = -100;
      last_ref = -100;
      ref_mark = 0;
      cyc      = 0;
      prev_req = 1'b0;
    end
    else
    begin
      cyc++;
      check("ack with RD/WR", 32'(cmd_o == CMD_RD || cmd_o == CMD_WR), 32'(ack_o));
      check("refresh interval", 1, 32'((cyc - ref_mark) <= REF_SPAN));
      if (ack_o)
        ack_cnt++;
      if (cmd_o == CMD_REF)
      begin
        check("banks closed at REF", 0, 32'(model_open));
        check("REF to REF spacing", 1, 32'((cyc - last_ref) >= `T_RC_CYC));
        last_ref = cyc;
        ref_mark = cyc;
        ref_cnt++;
      end
      else if (cmd_o == CMD_PRE && addr_o[10])
      begin
        // Precharge of all banks ahead of refresh
        for (int i = 0; i < NBANKS; i++)
        begin
          if (model_open[i])
            check("ACT to PRE-all spacing", 1, 32'((cyc - act_t[i]) >= `T_RAS_CYC));
          model_open[i] = 1'b0;
          pre_t[i]      = cyc;
        end
      end
      else if (cmd_o != CMD_NOP)
      begin
        check("command with request", 1, 32'(prev_req));
        exp_cmd = expect_cmd(prev_ba, prev_row, prev_col, prev_we, exp_addr);
        check("command", 32'(exp_cmd), 32'(cmd_o));
        check("bank", 32'(prev_ba), 32'(ba_o));
        check("address", 32'(exp_addr), 32'(addr_o));
        b = int'(ba_o);
        case (cmd_o)
          CMD_ACT:
          begin
            check("PRE to ACT spacing", 1, 32'((cyc - pre_t[b]) >= `T_RP_CYC));
            check("ACT to ACT spacing", 1, 32'((cyc - last_act) >= `T_RC_CYC));
            check("REF to ACT spacing", 1, 32'((cyc - last_ref) >= `T_RC_CYC));
            model_open[b] = 1'b1;
            model_row[b]  = row_t'(addr_o);
            act_t[b]      = cyc;
            last_act      = cyc;
            act_cnt++;
          end
          CMD_PRE:
          begin
            check("ACT to PRE spacing", 1, 32'((cyc - act_t[b]) >= `T_RAS_CYC));
            model_open[b] = 1'b0;
            pre_t[b]      = cyc;
            pre_cnt++;
          end
          default: check("ACT to RD/WR spacing", 1, 32'((cyc - act_t[b]) >= `T_RCD_CYC));
        endcase
      end
      // Blocked in the ack cycle
      prev_req = req_i & ~ack_o;
      prev_we  = we_i;
      prev_ba  = req_ba_i;
      prev_row = req_row_i;
      prev_col = req_col_i;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial
  begin
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    req_ba_i  = '0;
    req_row_i = '0;
    req_col_i = '0;
    seed      = 32'ha1b594ec;
    ack_cnt   = 0;
    act_cnt   = 0;
    pre_cnt   = 0;
    ref_cnt   = 0;
    req_cnt   = 0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Quiet bus before any request
    repeat (5)
    begin
      step();
      check("idle cmd after reset", 32'(CMD_NOP), 32'(cmd_o));
      check("idle ack after reset", 0, 32'(ack_o));
    end

    // Closed bank then row hit then row miss
    a0 = act_cnt;
    issue_request(2'd1, 13'h005, 9'h033, 1'b0);
    check("closed bank opens once", a0 + 1, act_cnt);
    a0 = act_cnt;
    issue_request(2'd1, 13'h005, 9'h034, 1'b1);
    check("row hit without ACT", a0, act_cnt);
    a0 = act_cnt;
    p0 = pre_cnt;
    issue_request(2'd1, 13'h009, 9'h010, 1'b0);
    check("row miss PRE", p0 + 1, pre_cnt);
    check("row miss ACT", a0 + 1, act_cnt);

    // Continuous random stream over few rows so that hits occur
    for (int i = 0; i < N_RAND; i++)
      issue_request(bank_t'($random(seed)), row_t'($random(seed) & 3),
                    col_t'($random(seed)), 1'($random(seed)));

    req_i = 1'b0;
    repeat (3) step();
    check("one ack per request", req_cnt, ack_cnt);
    check("refresh issued", 1, 32'(ref_cnt > 0));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
